//--- string_defines.svh
`ifndef STRING_DEFINES_SVH
`define STRING_DEFINES_SVH

// Datapath and register width
`define STR_DATA_W 16

// Physical address, segment * 16 + offset
`define STR_PADDR_W 20
`define STR_SEG_SHIFT 4

// Pointer increments per element
`define STR_STEP_BYTE 1
`define STR_STEP_WORD 2

`endif

//--- string_pkg.sv
`include "string_defines.svh"

package string_pkg;

    typedef enum logic [2:0] {
        STR_STM,
        STR_LDM,
        STR_MOVBK,
        STR_CMPBK,
        STR_CMPM
    } str_op_e;

    typedef enum logic [2:0] {
        REP_NONE,
        REP_C,
        REP_NC,
        REP_Z,
        REP_NZ
    } rep_cond_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,
        S_READ_SRC,
        S_READ_DST,
        S_WRITE,
        S_COMPARE,
        S_STEP,
        S_DONE
    } seq_state_e;

    // Access kinds from sequencer to data port
    localparam logic [1:0] ACC_RD_SRC = 2'd0; // DS0:IX or override:IX
    localparam logic [1:0] ACC_RD_DST = 2'd1; // DS1:IY
    localparam logic [1:0] ACC_WR_DST = 2'd2;

    typedef struct packed {
        logic [`STR_DATA_W-1:0] aw;
        logic [`STR_DATA_W-1:0] cw;
        logic [`STR_DATA_W-1:0] ix;
        logic [`STR_DATA_W-1:0] iy;
        logic [`STR_DATA_W-1:0] ds0;
        logic [`STR_DATA_W-1:0] ds1;
    } str_regs_t;

    typedef struct packed {
        str_op_e                op;
        logic                   wide;
        logic                   dir;
        rep_cond_e              rep;
        logic                   seg_ovr_valid;
        logic [`STR_DATA_W-1:0] seg_ovr_value;
        str_regs_t              regs;
    } str_cmd_t;

    typedef struct packed {
        logic cy;
        logic z;
        logic s;
        logic v;
    } cmp_flags_t;

    typedef struct packed {
        logic [`STR_PADDR_W-1:0] paddr;
        logic                    write;
        logic                    wide;
        logic [`STR_DATA_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   step_ix;
        logic                   step_iy;
        logic                   dec_cw;
        logic                   load_aw;
        logic [`STR_DATA_W-1:0] load_data;
    } reg_update_t;

endpackage

//--- string_data_port.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_data_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   acc_go,
    input  logic [1:0]             acc_kind,
    input  string_pkg::str_regs_t  regs,
    input  logic                   seg_ovr_valid,
    input  logic [`STR_DATA_W-1:0] seg_ovr_value,
    input  logic                   wide,
    input  logic                   wdata_sel_aw,
    output logic [`STR_DATA_W-1:0] acc_data,
    output logic                   acc_done,
    output logic                   mem_req_valid,
    output string_pkg::mem_req_t   mem_req,
    input  logic                   mem_ready,
    input  logic [`STR_DATA_W-1:0] mem_rdata
);
    string_pkg::mem_req_t    req_q;
    logic                    valid_q;
    logic                    pend_q;
    logic [`STR_DATA_W-1:0]  hold_q; // Last read word
    logic [`STR_DATA_W-1:0]  seg;
    logic [`STR_DATA_W-1:0]  off;
    logic [`STR_PADDR_W-1:0] paddr;

    always_comb begin
        if (acc_kind == string_pkg::ACC_RD_SRC) begin
            seg = seg_ovr_valid ? seg_ovr_value : regs.ds0;
            off = regs.ix;
        end else begin
            seg = regs.ds1; // Destination never overridden
            off = regs.iy;
        end
    end

    assign paddr = ({{(`STR_PADDR_W-`STR_DATA_W){1'b0}}, seg} << `STR_SEG_SHIFT)
                 + {{(`STR_PADDR_W-`STR_DATA_W){1'b0}}, off};

    // AW for STM and CMPM, otherwise the kept read word
    assign acc_data = wdata_sel_aw ? regs.aw : hold_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            valid_q <= acc_go;
            if (acc_go)
                pend_q <= 1'b1;
            else if (mem_ready)
                pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_go) begin
            req_q.paddr <= paddr;
            req_q.write <= (acc_kind == string_pkg::ACC_WR_DST);
            req_q.wide  <= wide;
            req_q.wdata <= acc_data;
        end
        if (mem_ready && !req_q.write)
            hold_q <= req_q.wide ? mem_rdata : {8'h00, mem_rdata[7:0]}; // Byte in low lane
    end

    assign acc_done      = pend_q & mem_ready;
    assign mem_req_valid = valid_q;
    assign mem_req       = req_q;

    a_ready_has_req: assert property (@(posedge clk) disable iff (reset)
        mem_ready |-> pend_q);

endmodule

//--- string_index_regs.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_index_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  string_pkg::str_regs_t    regs_in,
    input  logic                     wide,
    input  logic                     dir,
    input  string_pkg::reg_update_t  upd,
    output string_pkg::str_regs_t    regs,
    output logic                     cw_zero
);
    logic [`STR_DATA_W-1:0] step;

    assign step = wide ? `STR_DATA_W'(`STR_STEP_WORD) : `STR_DATA_W'(`STR_STEP_BYTE);

    // Direction flag set means walk downward
    function automatic logic [`STR_DATA_W-1:0] next_ptr(
        input logic [`STR_DATA_W-1:0] ptr,
        input logic [`STR_DATA_W-1:0] inc,
        input logic                   down
    );
        logic [`STR_DATA_W-1:0] nxt;
        if (down)
            nxt = ptr - inc;
        else
            nxt = ptr + inc;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (load) begin
            regs <= regs_in;
        end else begin
            if (upd.step_ix)
                regs.ix <= next_ptr(regs.ix, step, dir);
            if (upd.step_iy)
                regs.iy <= next_ptr(regs.iy, step, dir);
            if (upd.dec_cw)
                regs.cw <= regs.cw - `STR_DATA_W'(1);
            if (upd.load_aw) begin
                if (wide)
                    regs.aw <= upd.load_data;
                else
                    regs.aw[7:0] <= upd.load_data[7:0]; // AH kept
            end
        end
    end

    assign cw_zero = (regs.cw == '0);

endmodule

//--- string_compare.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_compare (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmp_go,
    input  logic                   wide,
    input  logic [`STR_DATA_W-1:0] ta,
    input  logic [`STR_DATA_W-1:0] tb,
    output logic                   cmp_valid,
    output string_pkg::cmp_flags_t flags
);
    logic [`STR_DATA_W:0]   diff_w; // Extra bit holds the borrow
    logic [8:0]             diff_b;
    string_pkg::cmp_flags_t next_flags;

    always_comb begin
        diff_w = {1'b0, ta} - {1'b0, tb};
        diff_b = {1'b0, ta[7:0]} - {1'b0, tb[7:0]};
        if (wide) begin
            next_flags.cy = diff_w[`STR_DATA_W];
            next_flags.z  = (diff_w[`STR_DATA_W-1:0] == '0);
            next_flags.s  = diff_w[`STR_DATA_W-1];
            next_flags.v  = (ta[`STR_DATA_W-1] ^ tb[`STR_DATA_W-1])
                          & (ta[`STR_DATA_W-1] ^ diff_w[`STR_DATA_W-1]);
        end else begin
            next_flags.cy = diff_b[8];
            next_flags.z  = (diff_b[7:0] == 8'h00);
            next_flags.s  = diff_b[7];
            next_flags.v  = (ta[7] ^ tb[7]) & (ta[7] ^ diff_b[7]);
        end
    end

    // Flags hold until the next compare
    always_ff @(posedge clk) begin
        if (reset) begin
            cmp_valid <= 1'b0;
            flags     <= '0;
        end else begin
            cmp_valid <= cmp_go;
            if (cmp_go)
                flags <= next_flags;
        end
    end

endmodule

//--- string_sequencer.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  string_pkg::str_op_e      op,
    input  logic                     wide,
    input  logic                     dir,
    input  string_pkg::rep_cond_e    rep,
    input  logic                     cw_zero,
    output logic                     acc_go,
    output logic [1:0]               acc_kind,
    input  logic                     acc_done,
    output logic                     cmp_go,
    input  logic                     cmp_valid,
    input  string_pkg::cmp_flags_t   cmp_flags,
    output string_pkg::reg_update_t  upd,
    input  logic [`STR_DATA_W-1:0]   acc_data,
    output logic                     busy,
    output logic                     done
);
    string_pkg::seq_state_e state;
    string_pkg::str_op_e    op_q;
    string_pkg::rep_cond_e  rep_q;
    logic                   wide_q;
    logic                   dir_q;
    logic                   wait_q; // Access outstanding
    logic                   is_cmp;
    logic                   cond_ok;
    logic                   more;

    assign is_cmp = (op_q == string_pkg::STR_CMPBK) || (op_q == string_pkg::STR_CMPM);

    always_comb begin
        case (rep_q)
            string_pkg::REP_Z:  cond_ok = cmp_flags.z;
            string_pkg::REP_NZ: cond_ok = !cmp_flags.z;
            string_pkg::REP_C:  cond_ok = cmp_flags.cy;
            string_pkg::REP_NC: cond_ok = !cmp_flags.cy;
            default:            cond_ok = 1'b1;
        endcase
    end

    // Another element after this step
    assign more = (rep_q != string_pkg::REP_NONE) && (!is_cmp || cond_ok);

    assign acc_go = ((state == string_pkg::S_READ_SRC) || (state == string_pkg::S_READ_DST)
                  || (state == string_pkg::S_WRITE)) && !wait_q;

    always_comb begin
        case (state)
            string_pkg::S_READ_SRC: acc_kind = string_pkg::ACC_RD_SRC;
            string_pkg::S_READ_DST: acc_kind = string_pkg::ACC_RD_DST;
            default:                acc_kind = string_pkg::ACC_WR_DST;
        endcase
    end

    // Second operand sampled straight off the read
    assign cmp_go = (state == string_pkg::S_READ_DST) && acc_done;

    always_comb begin
        upd = '0;
        upd.dec_cw = (state == string_pkg::S_CHECK) && (rep_q != string_pkg::REP_NONE)
                   && !cw_zero;
        if (state == string_pkg::S_STEP) begin
            upd.step_ix = op_q inside {string_pkg::STR_LDM, string_pkg::STR_MOVBK,
                                       string_pkg::STR_CMPBK};
            upd.step_iy = (op_q != string_pkg::STR_LDM);
            upd.load_aw = (op_q == string_pkg::STR_LDM);
        end
        upd.load_data = acc_data;
    end

    assign busy = (state != string_pkg::S_IDLE) && (state != string_pkg::S_DONE);
    assign done = (state == string_pkg::S_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= string_pkg::S_IDLE;
            wait_q <= 1'b0;
            op_q   <= string_pkg::STR_STM;
            rep_q  <= string_pkg::REP_NONE;
            wide_q <= 1'b0;
            dir_q  <= 1'b0;
        end else begin
            if (acc_done)
                wait_q <= 1'b0;
            else if (acc_go)
                wait_q <= 1'b1;

            case (state)
                string_pkg::S_IDLE: begin
                    if (start) begin
                        op_q   <= op;
                        rep_q  <= rep;
                        wide_q <= wide;
                        dir_q  <= dir;
                        state  <= string_pkg::S_CHECK;
                    end
                end
                string_pkg::S_CHECK: begin
                    if ((rep_q != string_pkg::REP_NONE) && cw_zero)
                        state <= string_pkg::S_DONE;
                    else if (op_q == string_pkg::STR_STM)
                        state <= string_pkg::S_WRITE;
                    else if (op_q == string_pkg::STR_CMPM)
                        state <= string_pkg::S_READ_DST;
                    else
                        state <= string_pkg::S_READ_SRC;
                end
                string_pkg::S_READ_SRC: begin
                    if (acc_done) begin
                        if (op_q == string_pkg::STR_MOVBK)
                            state <= string_pkg::S_WRITE;
                        else if (op_q == string_pkg::STR_CMPBK)
                            state <= string_pkg::S_READ_DST;
                        else
                            state <= string_pkg::S_STEP; // LDM
                    end
                end
                string_pkg::S_READ_DST: begin
                    if (acc_done)
                        state <= string_pkg::S_COMPARE;
                end
                string_pkg::S_WRITE: begin
                    if (acc_done)
                        state <= string_pkg::S_STEP;
                end
                string_pkg::S_COMPARE: begin
                    if (cmp_valid)
                        state <= string_pkg::S_STEP;
                end
                string_pkg::S_STEP: begin
                    state <= more ? string_pkg::S_CHECK : string_pkg::S_DONE;
                end
                default: state <= string_pkg::S_IDLE; // S_DONE
            endcase
        end
    end

    a_one_access: assert property (@(posedge clk) disable iff (reset)
        acc_go |=> (!acc_go throughout acc_done[->1]));

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    // Width and direction are used live by the datapath
    a_cmd_held: assert property (@(posedge clk) disable iff (reset)
        busy |-> (wide == wide_q) && (dir == dir_q));

endmodule

//--- string_unit_top.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_unit_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  string_pkg::str_cmd_t   cmd,
    output logic                   busy,
    output logic                   done,
    output string_pkg::str_regs_t  result,
    output string_pkg::cmp_flags_t flags,
    output logic                   mem_req_valid,
    output string_pkg::mem_req_t   mem_req,
    input  logic                   mem_ready,
    input  logic [`STR_DATA_W-1:0] mem_rdata
);
    logic                    acc_go;
    logic [1:0]              acc_kind;
    logic                    acc_done;
    logic [`STR_DATA_W-1:0]  acc_data;
    logic                    cmp_go;
    logic                    cmp_valid;
    logic                    cw_zero;
    string_pkg::reg_update_t upd;

    string_sequencer seq_i (
        .clk, .reset, .start,
        .op(cmd.op), .wide(cmd.wide), .dir(cmd.dir), .rep(cmd.rep),
        .cw_zero,
        .acc_go, .acc_kind, .acc_done,
        .cmp_go, .cmp_valid, .cmp_flags(flags),
        .upd, .acc_data,
        .busy, .done
    );

    string_index_regs regs_i (
        .clk, .reset,
        .load(start), .regs_in(cmd.regs),
        .wide(cmd.wide), .dir(cmd.dir),
        .upd,
        .regs(result), .cw_zero
    );

    // AW is the store data for STM and the first operand for CMPM
    string_data_port port_i (
        .clk, .reset,
        .acc_go, .acc_kind,
        .regs(result),
        .seg_ovr_valid(cmd.seg_ovr_valid), .seg_ovr_value(cmd.seg_ovr_value),
        .wide(cmd.wide),
        .wdata_sel_aw((cmd.op == string_pkg::STR_STM) || (cmd.op == string_pkg::STR_CMPM)),
        .acc_data, .acc_done,
        .mem_req_valid, .mem_req, .mem_ready, .mem_rdata
    );

    string_compare cmp_i (
        .clk, .reset,
        .cmp_go, .wide(cmd.wide),
        .ta(acc_data), .tb(mem_rdata), // Read lands in the cmp_go cycle
        .cmp_valid, .flags
    );

endmodule

//--- string_tb.sv
`timescale 1ns/1ps
`include "string_defines.svh"

module string_tb;
    typedef struct packed {
        string_pkg::str_regs_t  regs;
        string_pkg::cmp_flags_t flags;
    } expect_t;

    localparam int MEM_BYTES    = 1 << `STR_PADDR_W;
    localparam int DONE_TIMEOUT = 2000;

    logic                   clk;
    logic                   reset;
    logic                   start;
    string_pkg::str_cmd_t   cmd;
    logic                   busy;
    logic                   done;
    string_pkg::str_regs_t  result;
    string_pkg::cmp_flags_t flags;
    logic                   mem_req_valid;
    string_pkg::mem_req_t   mem_req;
    logic                   mem_ready;
    logic [`STR_DATA_W-1:0] mem_rdata;
    logic [7:0]             mem [MEM_BYTES];
    logic [7:0]             ref_mem [MEM_BYTES]; // Expected memory contents
    string_pkg::mem_req_t   req_hold;
    int                     lat_cnt;
    string_pkg::cmp_flags_t exp_flags;

    string_unit_top dut_i (.*);

    always #10 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("Error: %s", what);
        $display("Test failed");
        $fatal(1, "stopped after error");
    endtask

    function automatic logic [19:0] phys(input logic [15:0] seg, input logic [15:0] off);
        return {seg, 4'h0} + {4'h0, off};
    endfunction

    function automatic logic [15:0] ref_read(input logic [15:0] seg, input logic [15:0] off,
                                             input logic wide);
        logic [19:0] pa;
        pa = phys(seg, off);
        return wide ? {ref_mem[pa + 20'd1], ref_mem[pa]} : {8'h00, ref_mem[pa]};
    endfunction

    function automatic void ref_write(input logic [15:0] seg, input logic [15:0] off,
                                      input logic [15:0] val, input logic wide);
        logic [19:0] pa;
        pa = phys(seg, off);
        ref_mem[pa] = val[7:0];
        if (wide)
            ref_mem[pa + 20'd1] = val[15:8];
    endfunction

    // First minus second, signed and unsigned views kept apart
    function automatic string_pkg::cmp_flags_t cmp_ref(input logic [15:0] a,
                                                      input logic [15:0] b, input logic wide);
        string_pkg::cmp_flags_t f;
        int ua, ub, sa, sb, lim, diff, sd;
        if (wide) begin
            ua  = int'(a);
            ub  = int'(b);
            sa  = int'($signed(a));
            sb  = int'($signed(b));
            lim = 32768;
        end else begin
            ua  = int'(a[7:0]);
            ub  = int'(b[7:0]);
            sa  = int'($signed(a[7:0]));
            sb  = int'($signed(b[7:0]));
            lim = 128;
        end
        diff = (ua - ub) & (2 * lim - 1);
        sd   = sa - sb;
        f.cy = (ua < ub);
        f.z  = (diff == 0);
        f.s  = (diff >= lim);
        f.v  = (sd >= lim) || (sd < -lim);
        return f;
    endfunction

    function automatic expect_t ref_run(input string_pkg::str_cmd_t c,
                                        input string_pkg::cmp_flags_t f_in);
        expect_t     e;
        logic [15:0] step;
        logic [15:0] src_seg;
        logic        go;
        e.regs  = c.regs;
        e.flags = f_in;
        step    = c.wide ? 16'd2 : 16'd1;
        src_seg = c.seg_ovr_valid ? c.seg_ovr_value : c.regs.ds0;
        go      = 1'b1;
        while (go) begin
            if (c.rep != string_pkg::REP_NONE && e.regs.cw == 16'd0) begin
                go = 1'b0;
            end else begin
                if (c.rep != string_pkg::REP_NONE)
                    e.regs.cw = e.regs.cw - 16'd1;
                case (c.op)
                    string_pkg::STR_STM:
                        ref_write(e.regs.ds1, e.regs.iy, e.regs.aw, c.wide);
                    string_pkg::STR_LDM:
                        if (c.wide)
                            e.regs.aw = ref_read(src_seg, e.regs.ix, 1'b1);
                        else
                            e.regs.aw[7:0] = 8'(ref_read(src_seg, e.regs.ix, 1'b0));
                    string_pkg::STR_MOVBK:
                        ref_write(e.regs.ds1, e.regs.iy,
                                  ref_read(src_seg, e.regs.ix, c.wide), c.wide);
                    string_pkg::STR_CMPBK:
                        e.flags = cmp_ref(ref_read(src_seg, e.regs.ix, c.wide),
                                          ref_read(e.regs.ds1, e.regs.iy, c.wide), c.wide);
                    default: // CMPM
                        e.flags = cmp_ref(e.regs.aw, ref_read(e.regs.ds1, e.regs.iy, c.wide),
                                          c.wide);
                endcase
                if (c.op != string_pkg::STR_STM && c.op != string_pkg::STR_CMPM)
                    e.regs.ix = c.dir ? e.regs.ix - step : e.regs.ix + step;
                if (c.op != string_pkg::STR_LDM)
                    e.regs.iy = c.dir ? e.regs.iy - step : e.regs.iy + step;
                if (c.rep == string_pkg::REP_NONE)
                    go = 1'b0;
                else if (c.op == string_pkg::STR_CMPBK || c.op == string_pkg::STR_CMPM)
                    case (c.rep)
                        string_pkg::REP_Z:  go = e.flags.z;
                        string_pkg::REP_NZ: go = !e.flags.z;
                        string_pkg::REP_C:  go = e.flags.cy;
                        default:            go = !e.flags.cy;
                    endcase
            end
        end
        return e;
    endfunction

    // Memory answers each request after 1 to 4 cycles
    always @(posedge clk) begin
        #2;
        mem_ready = 1'b0;
        if (lat_cnt > 0) begin
            lat_cnt = lat_cnt - 1;
            if (lat_cnt == 0) begin
                if (req_hold.write) begin
                    mem[req_hold.paddr] = req_hold.wdata[7:0];
                    if (req_hold.wide)
                        mem[req_hold.paddr + 20'd1] = req_hold.wdata[15:8];
                end
                mem_rdata = {mem[req_hold.paddr + 20'd1], mem[req_hold.paddr]};
                mem_ready = 1'b1;
            end
        end
        if (mem_req_valid) begin
            if (lat_cnt != 0)
                abort_run("second memory request issued while one was pending");
            req_hold = mem_req;
            lat_cnt  = $urandom_range(4, 1);
        end
    end

    task automatic put_elem(input logic [15:0] seg, input logic [15:0] off,
                            input logic [15:0] val, input logic wide);
        logic [19:0] pa;
        pa          = phys(seg, off);
        mem[pa]     = val[7:0];
        ref_mem[pa] = val[7:0];
        if (wide) begin
            mem[pa + 20'd1]     = val[15:8];
            ref_mem[pa + 20'd1] = val[15:8];
        end
    endtask

    // Eight element pairs; REP_Z meets one mismatch at k, REP_NZ one match
    task automatic plant_buffers(input string_pkg::str_cmd_t c, input int k);
        logic [15:0] v;
        logic [15:0] step;
        logic [15:0] idx;
        int          e;
        step = c.wide ? 16'd2 : 16'd1;
        for (e = 0; e < 8; e++) begin
            v   = 16'($urandom);
            idx = 16'(e) * step;
            put_elem(c.regs.ds0, c.dir ? c.regs.ix - idx : c.regs.ix + idx, v, c.wide);
            if ((c.rep == string_pkg::REP_Z) == (e == k))
                v = v ^ 16'h0101;
            put_elem(c.regs.ds1, c.dir ? c.regs.iy - idx : c.regs.iy + idx, v, c.wide);
        end
    endtask

    function automatic string_pkg::str_cmd_t rand_cmd(input string_pkg::str_op_e op,
                                                      input string_pkg::rep_cond_e rep);
        string_pkg::str_cmd_t c;
        c.op            = op;
        c.rep           = rep;
        c.wide          = 1'($urandom);
        c.dir           = 1'($urandom);
        c.seg_ovr_valid = 1'b0;
        c.seg_ovr_value = 16'($urandom);
        c.regs          = {16'($urandom), 16'($urandom_range(8, 0)), 16'($urandom),
                           16'($urandom), 16'($urandom), 16'($urandom)};
        return c;
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic run_cmd(input string_pkg::str_cmd_t c);
        expect_t e;
        int      n;
        int      i;
        e         = ref_run(c, exp_flags);
        exp_flags = e.flags;
        cmd       = c;
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (busy !== 1'b1)
            abort_run("busy did not rise the cycle after start");
        n = 0;
        while (done !== 1'b1) begin
            if (n == DONE_TIMEOUT)
                abort_run("timed out waiting for done");
            if (busy !== 1'b1)
                abort_run("busy dropped before done");
            @(posedge clk);
            #2;
            n++;
        end
        check_val("busy", 32'(busy), 32'd0);
        check_val("result.aw", 32'(result.aw), 32'(e.regs.aw));
        check_val("result.cw", 32'(result.cw), 32'(e.regs.cw));
        check_val("result.ix", 32'(result.ix), 32'(e.regs.ix));
        check_val("result.iy", 32'(result.iy), 32'(e.regs.iy));
        check_val("result.ds0", 32'(result.ds0), 32'(e.regs.ds0));
        check_val("result.ds1", 32'(result.ds1), 32'(e.regs.ds1));
        check_val("flags", 32'(flags), 32'(e.flags));
        for (i = 0; i < MEM_BYTES; i++)
            if (mem[20'(i)] !== ref_mem[20'(i)])
                check_val($sformatf("mem[%05h]", i), 32'(mem[20'(i)]), 32'(ref_mem[20'(i)]));
        @(posedge clk);
        #2;
        check_val("done", 32'(done), 32'd0);
    endtask

    initial begin
        string_pkg::str_cmd_t c;
        int                   i;
        int                   n;
        int                   w;
        int                   d;
        void'($urandom(44));
        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        cmd       = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        lat_cnt   = 0;
        exp_flags = '0;
        for (i = 0; i < MEM_BYTES; i++) begin
            mem[20'(i)]     = 8'((i * 157) ^ (i >> 8) ^ (i >> 15));
            ref_mem[20'(i)] = mem[20'(i)];
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check_val("busy", 32'(busy), 32'd0);
        check_val("done", 32'(done), 32'd0);
        check_val("mem_req_valid", 32'(mem_req_valid), 32'd0);
        check_val("flags", 32'(flags), 32'd0);

        for (w = 0; w < 2; w++) begin
            for (d = 0; d < 2; d++) begin
                c      = rand_cmd(string_pkg::STR_STM, string_pkg::REP_NONE);
                c.wide = w[0];
                c.dir  = d[0];
                run_cmd(c);
                // Load the stored element back into a fresh AW
                c.op       = string_pkg::STR_LDM;
                c.regs.aw  = 16'($urandom);
                c.regs.ds0 = c.regs.ds1;
                c.regs.ix  = c.regs.iy;
                run_cmd(c);
            end
        end

        for (n = 0; n < 8; n++) begin
            c = rand_cmd(string_pkg::STR_MOVBK, string_pkg::REP_Z);
            if (n == 0)
                c.regs.cw = 16'd0;
            run_cmd(c);
        end

        for (n = 0; n < 8; n++) begin
            c = rand_cmd(string_pkg::STR_CMPBK, n[0] ? string_pkg::REP_NZ : string_pkg::REP_Z);
            c.regs.cw  = 16'd8;
            c.regs.ds1 = c.regs.ds0 + 16'h1000;
            plant_buffers(c, $urandom_range(7, 0));
            run_cmd(c);
        end

        for (n = 0; n < 8; n++) begin
            c = rand_cmd(string_pkg::STR_CMPM, n[0] ? string_pkg::REP_NC : string_pkg::REP_C);
            c.regs.cw = 16'd8;
            run_cmd(c);
        end

        // Source reads through the override, writes stay on DS1
        for (n = 0; n < 4; n++) begin
            c = rand_cmd(n[1] ? string_pkg::STR_MOVBK : string_pkg::STR_LDM,
                         n[0] ? string_pkg::REP_Z : string_pkg::REP_NONE);
            c.seg_ovr_valid = 1'b1;
            run_cmd(c);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
string_pkg.sv
string_data_port.sv
string_index_regs.sv
string_compare.sv
string_sequencer.sv
string_unit_top.sv
string_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module string_tb -f compile.f -o string_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/string_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
